// ==== source/goc_pkg.sv ====
package goc_pkg;

	typedef logic [7:0] byte_t;   // one bus or payload byte
	typedef logic [7:0] eid_t;    // event id, first byte of a frame
	typedef logic [6:0] count_t;  // payload bytes kept in the fifo
	typedef logic [21:0] speed_t; // clocks per pulse unit

	// summary of one received frame, handed on to the acknowledge
	typedef struct packed {
		eid_t   eid;
		count_t byte_count;
		logic   overflow;  // payload was cut at fifo depth
	} frame_info_t;

	// first byte of every acknowledge message
	localparam byte_t ACK_CODE = 8'h06;

endpackage

// ==== source/frame_receiver.sv ====
`timescale 1ns/1ns

module frame_receiver #(
	parameter goc_pkg::byte_t LINK_ADDR = 8'h66,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  goc_pkg::byte_t       ma_data,
	input  goc_pkg::byte_t       ma_addr,
	input  logic                 ma_data_valid,
	input  logic                 ma_frame_valid,
	input  logic                 busy,
	input  logic                 fifo_pop,
	output goc_pkg::byte_t       fifo_data,
	output logic                 fifo_empty,
	output logic                 frame_done,
	output goc_pkg::frame_info_t frame_info
);
	import goc_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

	byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [FILL_W-1:0] fill;   // bytes waiting in the fifo

	logic frame_q;      // ma_frame_valid one cycle ago
	logic first_seen;   // first strobe of this frame already taken
	logic accepted;     // this frame belongs to us
	logic wr_en;
	byte_t wr_data;
	eid_t eid;
	count_t byte_count;
	logic overflow;

	logic rd_en;

	assign rd_en = fifo_pop && !fifo_empty;
	assign fifo_empty = (fill == '0);
	assign fifo_data = mem[rd_ptr];
	assign frame_info = '{eid: eid, byte_count: byte_count, overflow: overflow};

	// frame tracking and accept decision
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_q <= 1'b0;
			first_seen <= 1'b0;
			accepted <= 1'b0;
			frame_done <= 1'b0;
			wr_en <= 1'b0;
			byte_count <= '0;
			overflow <= 1'b0;
		end else begin
			frame_q <= ma_frame_valid;
			frame_done <= accepted && frame_q && !ma_frame_valid; // falling edge
			wr_en <= 1'b0;
			if (!ma_frame_valid) begin
				first_seen <= 1'b0;
				accepted <= 1'b0;
			end else if (ma_data_valid) begin
				first_seen <= 1'b1;
				if (!first_seen) begin
					// frame_done still high means the transmitter has not raised busy yet
					if (ma_addr == LINK_ADDR && !busy && !frame_done) begin
						accepted <= 1'b1;
						byte_count <= '0;
						overflow <= 1'b0;
					end
				end else if (accepted) begin
					// fifo is drained before a new frame, so the kept count is its fill level
					if (byte_count < count_t'(FIFO_DEPTH)) begin
						wr_en <= 1'b1;
						byte_count <= byte_count + 1'b1;
					end else begin
						overflow <= 1'b1; // byte dropped
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ma_frame_valid && ma_data_valid) begin
			wr_data <= ma_data;
			if (!first_seen)
				eid <= ma_data;
		end
	end

	// circular payload fifo
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

// ==== source/pwm_transmitter.sv ====
`timescale 1ns/1ns

module pwm_transmitter (
	input  logic                 clk,
	input  logic                 reset,
	input  goc_pkg::speed_t      goc_speed,
	input  logic                 goc_polarity,
	input  logic                 frame_done,
	input  goc_pkg::frame_info_t frame_info,
	input  goc_pkg::byte_t       fifo_data,
	input  logic                 fifo_empty,
	output logic                 fifo_pop,
	output logic                 busy,
	output logic                 ack_request,
	output goc_pkg::frame_info_t ack_info,
	output logic                 goc_pad
);
	import goc_pkg::*;

	typedef enum logic [1:0] {
		tx_idle,
		tx_load,    // fetch first byte or finish an empty frame
		tx_symbol   // shifting bits onto the line
	} tx_state_t;

	tx_state_t state;

	speed_t unit_cnt;        // clocks within the current unit
	logic [1:0] phase;       // unit within the bit, 0 to 2
	logic [2:0] bit_idx;     // msb first
	byte_t shift_q;
	frame_info_t info_q;

	logic unit_end;
	logic byte_end;
	logic load_byte;
	logic line;

	assign unit_end = (unit_cnt == goc_speed - 1'b1);
	assign byte_end = unit_end && (phase == 2'd2) && (bit_idx == 3'd0);
	assign load_byte = !fifo_empty &&
		((state == tx_load) || (state == tx_symbol && byte_end));
	assign fifo_pop = load_byte;
	assign ack_info = info_q;

	// pad code: unit 0 high, unit 1 carries the bit, unit 2 low
	always_comb begin
		line = 1'b0;
		if (state == tx_symbol) begin
			case (phase)
				2'd0: line = 1'b1;
				2'd1: line = shift_q[bit_idx];
				default: line = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tx_idle;
			busy <= 1'b0;
			ack_request <= 1'b0;
			unit_cnt <= '0;
			phase <= 2'd0;
			bit_idx <= 3'd7;
		end else begin
			ack_request <= 1'b0;
			case (state)
				tx_idle: begin
					if (frame_done) begin
						state <= tx_load;
						busy <= 1'b1;
					end
				end
				tx_load: begin
					if (fifo_empty) begin // eid only, nothing to send
						state <= tx_idle;
						busy <= 1'b0;
						ack_request <= 1'b1;
					end else begin
						state <= tx_symbol;
						unit_cnt <= '0;
						phase <= 2'd0;
						bit_idx <= 3'd7;
					end
				end
				tx_symbol: begin
					if (unit_end) begin
						unit_cnt <= '0;
						if (phase == 2'd2) begin
							phase <= 2'd0;
							bit_idx <= bit_idx - 1'b1; // wraps to 7 for the next byte
							if (bit_idx == 3'd0 && fifo_empty) begin
								state <= tx_idle;
								busy <= 1'b0;
								ack_request <= 1'b1;
							end
						end else begin
							phase <= phase + 1'b1;
						end
					end else begin
						unit_cnt <= unit_cnt + 1'b1;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_byte)
			shift_q <= fifo_data;
		if (state == tx_idle && frame_done)
			info_q <= frame_info; // held until the acknowledge has it
	end

	always_ff @(posedge clk) begin
		if (reset)
			goc_pad <= goc_polarity;
		else
			goc_pad <= line ^ goc_polarity;
	end

endmodule

// ==== source/ack_generator.sv ====
`timescale 1ns/1ns

module ack_generator (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ack_request,
	input  goc_pkg::frame_info_t ack_info,
	output goc_pkg::byte_t       ack_data,
	output logic                 ack_data_valid,
	output logic                 ack_frame_valid
);
	import goc_pkg::*;

	// state names the byte currently on ack_data
	typedef enum logic [1:0] {
		ack_idle,
		ack_code,
		ack_eid,
		ack_status
	} ack_state_t;

	ack_state_t state;
	frame_info_t info_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ack_idle;
			ack_data_valid <= 1'b0;
			ack_frame_valid <= 1'b0;
		end else begin
			case (state)
				ack_idle: begin
					if (ack_request) begin
						state <= ack_code;
						ack_data_valid <= 1'b1;
						ack_frame_valid <= 1'b1;
					end
				end
				ack_code: state <= ack_eid;
				ack_eid: state <= ack_status;
				default: begin // last byte out, close the message
					state <= ack_idle;
					ack_data_valid <= 1'b0;
					ack_frame_valid <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ack_idle: begin
				ack_data <= ACK_CODE;
				if (ack_request)
					info_q <= ack_info;
			end
			ack_code: ack_data <= info_q.eid;
			ack_eid: ack_data <= {info_q.overflow, info_q.byte_count}; // status byte
			default: ack_data <= ack_data;
		endcase
	end

endmodule

// ==== source/goc_link.sv ====
`timescale 1ns/1ns

module goc_link #(
	parameter goc_pkg::byte_t LINK_ADDR = 8'h66,
	parameter int FIFO_DEPTH = 16   // 2 to 127
) (
	input  logic            clk,
	input  logic            reset,
	input  goc_pkg::byte_t  ma_data,
	input  goc_pkg::byte_t  ma_addr,
	input  logic            ma_data_valid,
	input  logic            ma_frame_valid,
	input  goc_pkg::speed_t goc_speed,
	input  logic            goc_polarity,
	output logic            goc_pad,
	output goc_pkg::byte_t  ack_data,
	output logic            ack_data_valid,
	output logic            ack_frame_valid
);
	import goc_pkg::*;

	byte_t fifo_data;
	logic fifo_empty;
	logic fifo_pop;
	logic busy;
	logic frame_done;
	frame_info_t frame_info;
	logic ack_request;
	frame_info_t ack_info;

	frame_receiver #(
		.LINK_ADDR (LINK_ADDR),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_receiver (
		.clk           (clk),
		.reset         (reset),
		.ma_data       (ma_data),
		.ma_addr       (ma_addr),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.busy          (busy),
		.fifo_pop      (fifo_pop),
		.fifo_data     (fifo_data),
		.fifo_empty    (fifo_empty),
		.frame_done    (frame_done),
		.frame_info    (frame_info)
	);

	pwm_transmitter u_transmitter (
		.clk         (clk),
		.reset       (reset),
		.goc_speed   (goc_speed),
		.goc_polarity(goc_polarity),
		.frame_done  (frame_done),
		.frame_info  (frame_info),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty),
		.fifo_pop    (fifo_pop),
		.busy        (busy),
		.ack_request (ack_request),
		.ack_info    (ack_info),
		.goc_pad     (goc_pad)
	);

	ack_generator u_ack (
		.clk            (clk),
		.reset          (reset),
		.ack_request    (ack_request),
		.ack_info       (ack_info),
		.ack_data       (ack_data),
		.ack_data_valid (ack_data_valid),
		.ack_frame_valid(ack_frame_valid)
	);

endmodule

// ==== verification/goc_link_asserts.sv ====
`timescale 1ns/1ns

module goc_link_asserts (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic goc_pad,
	input logic goc_polarity,
	input logic ack_data_valid,
	input logic ack_frame_valid
);

	// byte strobes only inside the message window
	assert property (@(posedge clk) disable iff (reset) ack_data_valid |-> ack_frame_valid)
		else $error("ack_data_valid seen without ack_frame_valid");

	assert property (@(posedge clk) disable iff (reset)
		$rose(ack_frame_valid) |-> ack_frame_valid [*3] ##1 !ack_frame_valid)
		else $error("ack_frame_valid was not high for exactly 3 cycles");

	// the pad register follows the polarity one clock later while idle
	assert property (@(posedge clk) disable iff (reset)
		!busy && $past(!busy) |-> goc_pad == $past(goc_polarity))
		else $error("goc_pad left its idle level while busy was low");

endmodule

bind goc_link goc_link_asserts u_asserts (
	.clk            (clk),
	.reset          (reset),
	.busy           (busy),
	.goc_pad        (goc_pad),
	.goc_polarity   (goc_polarity),
	.ack_data_valid (ack_data_valid),
	.ack_frame_valid(ack_frame_valid)
);

// ==== verification/goc_link_tb.sv ====
`timescale 1ns/1ns

module goc_link_tb;
	import goc_pkg::*;

	localparam int DEPTH = 16;

	logic clk;
	logic reset;
	byte_t ma_data;
	byte_t ma_addr;
	logic ma_data_valid;
	logic ma_frame_valid;
	speed_t goc_speed;
	logic goc_polarity;
	logic goc_pad;
	byte_t ack_data;
	logic ack_data_valid;
	logic ack_frame_valid;

	byte_t payload [20];
	byte_t sent [$];   // bytes rebuilt from the pad
	byte_t acks [$];
	int pulse_count;

	goc_link #(.LINK_ADDR(8'h66), .FIFO_DEPTH(DEPTH)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped after a failed check");
	endtask

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		assert (got === exp)
			else stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	// eid first, then payload, with random idle gaps between strobes
	task automatic send_frame(input byte_t addr, input byte_t eid, input int len);
		@(posedge clk);
		ma_frame_valid <= 1'b1;
		for (int i = 0; i <= len; i++) begin
			repeat ($urandom % 3) @(posedge clk);
			@(posedge clk);
			ma_addr <= addr;
			if (i == 0)
				ma_data <= eid;
			else
				ma_data <= payload[i-1];
			ma_data_valid <= 1'b1;
			@(posedge clk);
			ma_data_valid <= 1'b0;
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0;
	endtask

	// decode pad pulses and collect acknowledge bytes until the message closes
	task automatic watch_link(input int limit, output bit timed_out);
		int high_len;
		int bits;
		int cycles;
		byte_t shreg;
		sent.delete();
		acks.delete();
		pulse_count = 0;
		high_len = 0;
		bits = 0;
		cycles = 0;
		timed_out = 1'b0;
		while (!(acks.size() >= 3 && !ack_frame_valid)) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				timed_out = 1'b1;
				break;
			end
			if (goc_pad ^ goc_polarity) begin
				high_len++;
			end else if (high_len > 0) begin
				assert (high_len == int'(goc_speed) || high_len == 2 * int'(goc_speed))
					else stop_run($sformatf("pad pulse of %0d clocks is no symbol", high_len));
				shreg = {shreg[6:0], high_len == 2 * int'(goc_speed)}; // long pulse is a 1
				pulse_count++;
				bits++;
				if (bits == 8) begin
					sent.push_back(shreg);
					bits = 0;
				end
				high_len = 0;
			end
			if (ack_data_valid)
				acks.push_back(ack_data);
		end
	endtask

	initial begin
		int fd;
		int code;
		int speed;
		int pol;
		int len;
		int acc;
		int kept;
		byte_t addr;
		byte_t eid;
		byte_t status;
		byte_t b;
		bit timed_out;
		string line;
		void'($urandom(32'h39273703));
		reset = 1'b1;
		ma_data = '0;
		ma_addr = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		goc_speed = speed_t'(1);
		goc_polarity = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_byte("goc_pad", byte_t'(goc_pad), byte_t'(goc_polarity));
		compare_byte("ack_data_valid", byte_t'(ack_data_valid), 8'h00);
		compare_byte("ack_frame_valid", byte_t'(ack_frame_valid), 8'h00);

		fd = $fopen("verification/goc_link_patterns.txt", "r");
		assert (fd != 0) else stop_run("the pattern file could not be opened");
		code = $fgets(line, fd); // two column description lines
		code = $fgets(line, fd);
		while ($fscanf(fd, "%h %d %d %h %d", addr, speed, pol, eid, len) == 5) begin
			for (int i = 0; i < len; i++) begin
				code = $fscanf(fd, "%h", b);
				payload[i] = b;
			end
			code = $fscanf(fd, "%d %h", acc, status);
			@(posedge clk);
			goc_speed <= speed_t'(speed);
			goc_polarity <= pol[0];
			repeat (2) @(posedge clk); // pad settles at the new idle level
			send_frame(addr, eid, len);
			kept = (len > DEPTH) ? DEPTH : len;
			watch_link((acc != 0) ? (kept + 1) * 24 * speed + 50 : 200, timed_out);
			if (acc != 0) begin
				assert (!timed_out)
					else stop_run($sformatf("no acknowledge for the frame with eid %h", eid));
				assert (acks.size() == 3)
					else stop_run($sformatf("acknowledge had %0d bytes, not 3", acks.size()));
				compare_byte("ack_data code", acks[0], ACK_CODE);
				compare_byte("ack_data eid", acks[1], eid);
				compare_byte("ack_data status", acks[2], status);
				assert (pulse_count == kept * 8 && sent.size() == kept)
					else stop_run($sformatf("pad sent %0d pulses for %0d bytes", pulse_count, kept));
				for (int i = 0; i < kept; i++)
					compare_byte("goc_pad byte", sent[i], payload[i]);
			end else begin
				assert (timed_out && pulse_count == 0 && acks.size() == 0)
					else stop_run("a frame to another address caused pad or acknowledge activity");
			end
			repeat ($urandom % 4) @(posedge clk);
		end
		$fclose(fd);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== goc_link.f ====
source/goc_pkg.sv
source/frame_receiver.sv
source/pwm_transmitter.sv
source/ack_generator.sv
source/goc_link.sv
verification/goc_link_asserts.sv
verification/goc_link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= goc_link_tb
FILELIST ?= goc_link.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/goc_link_patterns.txt ====
# addr(hex) speed(dec) polarity eid(hex) length(dec) payload bytes(hex, length of them)
# then accepted flag (1 = frame is for this link) and expected status byte(hex)
66 1 0 a1 3 de ad be 1 03
66 2 1 b2 1 5a 1 01
66 3 0 c3 0 1 00
55 1 0 d4 2 11 22 0 00
66 1 1 e5 20 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 10 20 30 40 1 90
66 4 0 f6 4 00 ff 81 7e 1 04
66 1 0 17 16 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 1 10
67 2 1 28 1 aa 0 00
66 2 1 39 2 c3 3c 1 02
